/* Bender.yml */
package:
  name: hyper_todram

sources:
  - files:
      - hw/hyper_pkg.sv
      - hw/lsab_cr.sv
      - hw/hyper_mvblck_todram.sv
      - hw/hyper_mcu_dram.sv
      - hw/hyper_todram_top.sv
  - target: test
    files:
      - tb/tb_hyper_todram.sv

/* hw/hyper_mcu_dram.sv */
// DRAM write collector and banks
`timescale 1ns/10ps
`default_nettype none

module hyper_mcu_dram (
	input  wire                              CLK,
	input  wire                              RST,
	input  wire  [hyper_pkg::WORD_W-1:0]     head_data,
	input  wire  hyper_pkg::mcu_cmd_t        mcu_cmd,
	// Combinational readback
	input  wire                              rd_bank,
	input  wire  [hyper_pkg::ADDR_W-1:0]     rd_addr,
	output logic [hyper_pkg::WORD_W-1:0]     rd_data
);

	logic [hyper_pkg::WORD_W-1:0] q_prev;   // Word that goes to the even address
	logic [hyper_pkg::WORD_W-1:0] q_cur;    // Word that goes to the odd address
	logic [hyper_pkg::ADDR_W-1:0] odd_addr;
	logic [hyper_pkg::WORD_W-1:0] bank_mem [hyper_pkg::N_BANK][2**hyper_pkg::ADDR_W];

	assign odd_addr = {mcu_cmd.coll_address[hyper_pkg::ADDR_W-1:1], 1'b1};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Two-word history
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Shifts every cycle, and the command enables pick out the popped words
	always_ff @(posedge CLK)
	begin
		q_prev <= q_cur;
		q_cur  <= head_data;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Byte-masked pair write
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge CLK)
	begin
		for (int b = 0; b < hyper_pkg::N_BANK; b++)
		begin
			if (mcu_cmd.request_access[b])
			begin
				for (int k = 0; k < 2; k++)
				begin
					// Bits 3:2 mask the even word, bits 1:0 the odd one
					if (mcu_cmd.we_array[2+k])
						bank_mem[b][mcu_cmd.coll_address][k*8 +: 8] <= q_prev[k*8 +: 8];
					if (mcu_cmd.we_array[k])
						bank_mem[b][odd_addr][k*8 +: 8] <= q_cur[k*8 +: 8];
				end
			end
		end
	end

	assign rd_data = bank_mem[rd_bank][rd_addr];

	// The mover aligns every pair on an even address
	a_even_pair : assert property (@(posedge CLK) disable iff (!RST)
		(mcu_cmd.request_access != '0) |-> !mcu_cmd.coll_address[0]);

endmodule

`default_nettype wire

/* hw/hyper_mvblck_todram.sv */
// LSAB to DRAM block mover
`timescale 1ns/10ps
`default_nettype none

module hyper_mvblck_todram (
	input  wire                                              CLK,
	input  wire                                              RST,
	input  wire  hyper_pkg::lsab_stat_t [hyper_pkg::N_SECT-1:0] lsab_stat,
	input  wire  hyper_pkg::move_req_t                       move_req,
	input  wire                                              issue,
	output logic                                             lsab_read,
	output logic [hyper_pkg::SECT_W-1:0]                     lsab_section,
	output logic                                             working,
	output hyper_pkg::move_res_t                             move_res,
	output hyper_pkg::mcu_cmd_t                              mcu_cmd
);

	hyper_pkg::lsab_stat_t          sel_stat;
	logic                           stop_n;        // A word is popped on this edge
	logic                           stop_prev_n;
	logic                           am_working;
	logic                           working_pre;
	logic [hyper_pkg::COUNT_W-1:0]  len_left;
	logic [hyper_pkg::COUNT_W-1:0]  count_q;
	logic [hyper_pkg::N_BANK-1:0]   bank_q;
	logic [hyper_pkg::ADDR_W-1:0]   track_addr;

	assign sel_stat = lsab_stat[lsab_section];
	assign stop_n   = lsab_read && !sel_stat.stop;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Block bookkeeping
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge CLK)
	begin
		if (!am_working)
		begin
			// Follow the request while idle so the issue edge captures it
			lsab_section <= move_req.section;
			len_left     <= move_req.count_req;
			count_q      <= move_req.count_req;
			bank_q       <= move_req.dram_sel;
			track_addr   <= move_req.start_address;
			stop_prev_n  <= 1'b0;
		end
		else
		begin
			if (stop_n)
				len_left <= len_left - 1'b1;
			track_addr  <= track_addr + 1'b1;   // Advances once per busy cycle
			stop_prev_n <= stop_n;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Control, results and commands
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			am_working  <= 1'b0;
			working_pre <= 1'b0;
			working     <= 1'b0;
			lsab_read   <= 1'b0;
			move_res    <= '0;
			mcu_cmd     <= '0;
		end
		else
		begin
			if (!am_working)
			begin
				am_working <= issue;
				lsab_read  <= issue && (move_req.count_req != '0);   // Zero words pops nothing
				mcu_cmd.request_access <= '0;
			end
			else
			begin
				if (stop_n)
					lsab_read <= (len_left > 1);
				else
				begin
					// Nothing popped this cycle, so the block is over
					am_working <= 1'b0;
					lsab_read  <= 1'b0;
					move_res.count_sent  <= count_q - len_left;
					move_res.irq         <= sel_stat.intr;
					move_res.abrupt_stop <= lsab_read;   // Still reading means the section ran dry
					move_res.ancill      <= sel_stat.ancill;
				end

				// Odd address closes a pair, the even half came one pop earlier
				if (track_addr[0])
				begin
					mcu_cmd.we_array       <= {stop_prev_n, stop_prev_n, stop_n, stop_n};
					mcu_cmd.coll_address   <= {track_addr[hyper_pkg::ADDR_W-1:1], 1'b0};
					mcu_cmd.request_access <= bank_q;
				end
				else
					mcu_cmd.request_access <= '0;
			end

			// Two extra cycles keep the host off until the last write has landed
			working_pre <= am_working;
			working     <= working_pre;
		end
	end

	a_access_onehot : assert property (@(posedge CLK) disable iff (!RST)
		$onehot0(mcu_cmd.request_access));

	a_read_busy : assert property (@(posedge CLK) disable iff (!RST)
		lsab_read |-> am_working);

endmodule

`default_nettype wire

/* hw/hyper_pkg.sv */
// Hyper to-DRAM shared types
`default_nettype none

package hyper_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sizes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int WORD_W     = 16;
	localparam int ANCILL_W   = 25;
	localparam int ADDR_W     = 9;   // 512 words per bank
	localparam int COUNT_W    = 6;
	localparam int N_SECT     = 4;
	localparam int SECT_W     = 2;
	localparam int LSAB_DEPTH = 16;
	localparam int LSAB_PTR_W = $clog2(LSAB_DEPTH);
	localparam int N_BANK     = 2;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Bundles
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// One entry of an LSAB section
	typedef struct packed {
		logic [WORD_W-1:0]   data;
		logic                intr;    // Interrupt flag carried with the word
		logic [ANCILL_W-1:0] ancill;
	} lsab_word_t;

	// Status of one section as seen from its head
	typedef struct packed {
		logic                stop;    // Section is empty
		logic                intr;
		logic [ANCILL_W-1:0] ancill;
	} lsab_stat_t;

	typedef struct packed {
		logic [ADDR_W-1:0]  start_address;
		logic [COUNT_W-1:0] count_req;
		logic [SECT_W-1:0]  section;
		logic [N_BANK-1:0]  dram_sel;    // One-hot bank, zero means no bank
	} move_req_t;

	typedef struct packed {
		logic [COUNT_W-1:0]  count_sent;
		logic                irq;
		logic                abrupt_stop;
		logic [ANCILL_W-1:0] ancill;
	} move_res_t;

	// Paired write towards the banks, live while request_access is non-zero
	typedef struct packed {
		logic [ADDR_W-1:0] coll_address;
		logic [3:0]        we_array;
		logic [N_BANK-1:0] request_access;
	} mcu_cmd_t;

endpackage

`default_nettype wire

/* hw/hyper_todram_top.sv */
// LSAB to DRAM subsystem top
`timescale 1ns/10ps
`default_nettype none

module hyper_todram_top (
	input  wire                                CLK,
	input  wire                                RST,
	input  wire                                wr_en,
	input  wire  [hyper_pkg::SECT_W-1:0]       wr_section,
	input  wire  hyper_pkg::lsab_word_t        wr_word,
	input  wire  hyper_pkg::move_req_t         move_req,
	input  wire                                issue,
	input  wire                                rd_bank,
	input  wire  [hyper_pkg::ADDR_W-1:0]       rd_addr,
	output wire                                working,
	output wire  hyper_pkg::move_res_t         move_res,
	output wire  [hyper_pkg::WORD_W-1:0]       rd_data
);

	wire hyper_pkg::lsab_stat_t [hyper_pkg::N_SECT-1:0] lsab_stat;
	wire                                                lsab_read;
	wire [hyper_pkg::SECT_W-1:0]                        lsab_section;
	wire [hyper_pkg::WORD_W-1:0]                        head_data;
	wire hyper_pkg::mcu_cmd_t                           mcu_cmd;

	lsab_cr u_lsab_cr (
		.CLK          (CLK),
		.RST          (RST),
		.wr_en        (wr_en),
		.wr_section   (wr_section),
		.wr_word      (wr_word),
		.lsab_read    (lsab_read),
		.lsab_section (lsab_section),
		.lsab_stat    (lsab_stat),
		.head_data    (head_data)
	);

	hyper_mvblck_todram u_mover (
		.CLK          (CLK),
		.RST          (RST),
		.lsab_stat    (lsab_stat),
		.move_req     (move_req),
		.issue        (issue),
		.lsab_read    (lsab_read),
		.lsab_section (lsab_section),
		.working      (working),
		.move_res     (move_res),
		.mcu_cmd      (mcu_cmd)
	);

	// Head word reaches the banks through the collector history
	hyper_mcu_dram u_mcu_dram (
		.CLK       (CLK),
		.RST       (RST),
		.head_data (head_data),
		.mcu_cmd   (mcu_cmd),
		.rd_bank   (rd_bank),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

endmodule

`default_nettype wire

/* hw/lsab_cr.sv */
// LSAB four-section line buffer
`timescale 1ns/10ps
`default_nettype none

module lsab_cr (
	input  wire                                              CLK,
	input  wire                                              RST,
	// Host write port
	input  wire                                              wr_en,
	input  wire  [hyper_pkg::SECT_W-1:0]                     wr_section,
	input  wire  hyper_pkg::lsab_word_t                      wr_word,
	// Pop port from the block mover
	input  wire                                              lsab_read,
	input  wire  [hyper_pkg::SECT_W-1:0]                     lsab_section,
	output wire  hyper_pkg::lsab_stat_t [hyper_pkg::N_SECT-1:0] lsab_stat,
	output logic [hyper_pkg::WORD_W-1:0]                     head_data
);

	wire hyper_pkg::lsab_word_t [hyper_pkg::N_SECT-1:0] heads;
	wire [hyper_pkg::N_SECT-1:0]                        push;
	wire [hyper_pkg::N_SECT-1:0]                        pop;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// One circular buffer per section
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar s = 0; s < hyper_pkg::N_SECT; s++)
	begin : g_sect
		hyper_pkg::lsab_word_t              mem [hyper_pkg::LSAB_DEPTH];
		logic [hyper_pkg::LSAB_PTR_W-1:0]   rd_ptr;
		logic [hyper_pkg::LSAB_PTR_W-1:0]   wr_ptr;
		logic [hyper_pkg::LSAB_PTR_W:0]     count;   // One bit wider to hold a full section
		logic                               empty;

		assign empty   = (count == '0);
		assign push[s] = wr_en && (wr_section == s) && (count != hyper_pkg::LSAB_DEPTH);
		assign pop[s]  = lsab_read && (lsab_section == s) && !empty;
		assign heads[s] = mem[rd_ptr];

		// A stale head is hidden once the section has drained
		assign lsab_stat[s] = '{
			stop:   empty,
			intr:   !empty && mem[rd_ptr].intr,
			ancill: empty ? '0 : mem[rd_ptr].ancill
		};

		always_ff @(posedge CLK)
		begin
			if (push[s])
				mem[wr_ptr] <= wr_word;
		end

		always_ff @(posedge CLK)
		begin
			if (!RST)
			begin
				rd_ptr <= '0;
				wr_ptr <= '0;
				count  <= '0;
			end
			else
			begin
				if (push[s])
					wr_ptr <= wr_ptr + 1'b1;   // Wraps at the section depth
				if (pop[s])
					rd_ptr <= rd_ptr + 1'b1;
				case ({push[s], pop[s]})
					2'b10:   count <= count + 1'b1;
					2'b01:   count <= count - 1'b1;
					default: count <= count;     // Push and pop together cancel out
				endcase
			end
		end

		// The pointers must still show a stored word whenever the head is popped
		a_no_underflow : assert property (@(posedge CLK) disable iff (!RST)
			pop[s] |-> (rd_ptr != wr_ptr) || (count == hyper_pkg::LSAB_DEPTH));

		a_bounded : assert property (@(posedge CLK) disable iff (!RST)
			count <= hyper_pkg::LSAB_DEPTH);
	end

	assign head_data = heads[lsab_section].data;   // Word that the next pop removes

endmodule

`default_nettype wire

/* src.f */
hw/hyper_pkg.sv
hw/lsab_cr.sv
hw/hyper_mvblck_todram.sv
hw/hyper_mcu_dram.sv
hw/hyper_todram_top.sv
tb/tb_hyper_todram.sv

/* tb/tb_hyper_todram.sv */
// LSAB to DRAM testbench
`timescale 1ns/10ps
`default_nettype none

module tb_hyper_todram;

	localparam int RESET_CYCLES   = 10;
	localparam int MOVE_CYCLES    = 64;   // Load, move and readback of one block
	localparam int FILL_MOVES     = 64;   // Two banks of 32 blocks of 16 words
	localparam int DIRECTED_MOVES = 13;
	localparam int RAND_MOVES     = 40;
	localparam int N_MOVES        = FILL_MOVES + DIRECTED_MOVES + RAND_MOVES;
	localparam int MEM_WORDS      = 2**hyper_pkg::ADDR_W;

	logic                          CLK = 1'b0;
	logic                          RST;
	logic                          wr_en;
	logic [hyper_pkg::SECT_W-1:0]  wr_section;
	hyper_pkg::lsab_word_t         wr_word;
	hyper_pkg::move_req_t          move_req;
	logic                          issue;
	logic                          rd_bank;
	logic [hyper_pkg::ADDR_W-1:0]  rd_addr;
	wire                           working;
	wire hyper_pkg::move_res_t     move_res;
	wire  [hyper_pkg::WORD_W-1:0]  rd_data;

	hyper_pkg::lsab_word_t         sect_q [hyper_pkg::N_SECT][$];   // Model of each section
	logic [hyper_pkg::WORD_W-1:0]  shadow [hyper_pkg::N_BANK][MEM_WORDS];
	hyper_pkg::move_res_t          exp_res;
	int                            exp_bank;
	int                            rd_first;   // Readback window of the current move
	int                            rd_count;
	int                            moves_issued = 0;
	int                            moves_checked = 0;
	int                            error_count = 0;
	logic [31:0]                   rng_state = 32'h4cb8_671b;

	always #20 CLK = ~CLK;

	hyper_todram_top u_hyper_todram_top (
		.CLK        (CLK),
		.RST        (RST),
		.wr_en      (wr_en),
		.wr_section (wr_section),
		.wr_word    (wr_word),
		.move_req   (move_req),
		.issue      (issue),
		.rd_bank    (rd_bank),
		.rd_addr    (rd_addr),
		.working    (working),
		.move_res   (move_res),
		.rd_data    (rd_data)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Random numbers and reporting
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = next_rand();
		return int'(r[31:16]) % n;   // Upper bits have the longer period
	endfunction

	function automatic hyper_pkg::lsab_word_t random_word();
		hyper_pkg::lsab_word_t w;
		logic [31:0]           r;
		r = next_rand();
		w.data = r[31:16];
		w.intr = r[15];
		r = next_rand();
		w.ancill = r[31:7];
		return w;
	endfunction

	task automatic fail_stop();
		error_count++;
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic report_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		$display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
		fail_stop();
	endtask

	task automatic report_plain(input string what);
		$display("Error at %0t: %s", $time, what);
		fail_stop();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pops the model section and updates the shadow banks like one block move
	function automatic hyper_pkg::move_res_t predict_move(input hyper_pkg::move_req_t r);
		hyper_pkg::move_res_t  res;
		hyper_pkg::lsab_word_t w;
		int                    avail;
		int                    sent;
		int                    bank;
		res   = '0;
		avail = sect_q[r.section].size();
		bank  = r.dram_sel[1] ? 1 : 0;
		sent  = (int'(r.count_req) < avail) ? int'(r.count_req) : avail;
		res.count_sent  = sent[hyper_pkg::COUNT_W-1:0];
		res.abrupt_stop = (int'(r.count_req) > avail);   // Section ran dry before the count
		for (int i = 0; i < sent; i++)
		begin
			w = sect_q[r.section].pop_front();
			shadow[bank][(int'(r.start_address) + i) % MEM_WORDS] = w.data;
		end
		if (sect_q[r.section].size() != 0)
		begin
			res.irq    = sect_q[r.section][0].intr;
			res.ancill = sect_q[r.section][0].ancill;
		end
		return res;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus tasks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic load_words(input int sect, input int n, input logic zero);
		hyper_pkg::lsab_word_t w;
		int                    room;
		room = hyper_pkg::LSAB_DEPTH - sect_q[sect].size();
		if (n > room)
			n = room;   // Never overfill, the LSAB would drop the word
		for (int i = 0; i < n; i++)
		begin
			w = zero ? '0 : random_word();
			@(posedge CLK);
			wr_en      <= 1'b1;
			wr_section <= sect[hyper_pkg::SECT_W-1:0];
			wr_word    <= w;
			sect_q[sect].push_back(w);
		end
		@(posedge CLK);
		wr_en <= 1'b0;
	endtask

	task automatic run_move(input int sect, input int bank, input int start, input int count,
			input int side_sect, input int side_n);
		hyper_pkg::move_req_t req;
		int                   last;
		req.start_address = start[hyper_pkg::ADDR_W-1:0];
		req.count_req     = count[hyper_pkg::COUNT_W-1:0];
		req.section       = sect[hyper_pkg::SECT_W-1:0];
		req.dram_sel      = (bank == 1) ? 2'b10 : 2'b01;
		exp_bank = bank;
		exp_res  = predict_move(req);
		last     = start + ((exp_res.count_sent == '0) ? 0 : int'(exp_res.count_sent) - 1);
		rd_first = start & ~1;   // Whole pairs, so the masked neighbours are read too
		rd_count = (last | 1) - rd_first + 1;
		@(posedge CLK);
		move_req <= req;
		issue    <= 1'b1;
		moves_issued++;
		@(posedge CLK);
		issue <= 1'b0;
		if (side_n > 0)
			load_words(side_sect, side_n, 1'b0);   // Another section fills during the move
		while (moves_checked < moves_issued)
			@(posedge CLK);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Processes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial
	begin : stimulus_proc
		int sect;
		RST        <= 1'b0;
		wr_en      <= 1'b0;
		wr_section <= '0;
		wr_word    <= '0;
		move_req   <= '0;
		issue      <= 1'b0;
		foreach (shadow[b, a])
			shadow[b][a] = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		RST <= 1'b1;

		// Both banks start from all zeros
		for (int b = 0; b < hyper_pkg::N_BANK; b++)
			for (int blk = 0; blk < MEM_WORDS / 16; blk++)
			begin
				load_words(0, 16, 1'b1);
				run_move(0, b, blk * 16, 16, 0, 0);
			end

		load_words(0, 16, 1'b0);
		run_move(0, 0, 100, 16, 0, 0);   // Even start, even count, full section
		load_words(1, 16, 1'b0);
		run_move(1, 1, 200, 16, 0, 0);
		load_words(1, 5, 1'b0);
		run_move(1, 1, 203, 5, 0, 0);    // Odd start and count
		load_words(1, 4, 1'b0);
		run_move(1, 1, 209, 4, 0, 0);
		load_words(2, 5, 1'b0);
		run_move(2, 0, 300, 9, 0, 0);    // Runs dry
		load_words(2, 10, 1'b0);
		run_move(2, 0, 310, 6, 0, 0);    // Head of the rest gives irq and tag
		for (int s = 0; s < hyper_pkg::N_SECT; s++)
		begin
			load_words(s, 8, 1'b0);
			run_move(s, s % 2, 24 + 50 * s, 5 + s, (s + 1) % hyper_pkg::N_SECT, 3);
		end
		run_move(3, 1, 400, 20, 0, 0);   // Drain section 3
		run_move(3, 0, 401, 0, 0, 0);
		run_move(3, 1, 403, 5, 0, 0);

		for (int m = 0; m < RAND_MOVES; m++)
		begin
			sect = rand_below(hyper_pkg::N_SECT);
			load_words(sect, rand_below(17), 1'b0);
			run_move(sect, rand_below(2), rand_below(MEM_WORDS), rand_below(21), 0, 0);
		end

		@(posedge CLK);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial
	begin : compare_proc
		int waited;
		int addr;
		rd_bank <= 1'b0;
		rd_addr <= '0;
		forever
		begin
			@(negedge CLK);
			if (moves_issued > moves_checked)
			begin
				waited = 0;
				while (working !== 1'b1)
				begin
					if (waited == MOVE_CYCLES)
						report_plain("working never rose after a move was issued");
					waited++;
					@(negedge CLK);
				end
				waited = 0;
				while (working !== 1'b0)
				begin
					if (waited == MOVE_CYCLES)
						report_plain("working never fell, the move did not end");
					waited++;
					@(negedge CLK);
				end
				assert (move_res === exp_res)
				else
					report_value("move_res", 64'(move_res), 64'(exp_res));
				for (int j = 0; j < rd_count; j++)
				begin
					addr = (rd_first + j) % MEM_WORDS;
					@(posedge CLK);
					rd_bank <= (exp_bank == 1);
					rd_addr <= addr[hyper_pkg::ADDR_W-1:0];
					@(negedge CLK);
					assert (rd_data === shadow[exp_bank][addr])
					else
						report_value("rd_data", 64'(rd_data), 64'(shadow[exp_bank][addr]));
				end
				moves_checked++;
			end
		end
	end

	initial
	begin : watchdog_proc
		repeat (RESET_CYCLES + N_MOVES * MOVE_CYCLES) @(posedge CLK);
		$display("Error: the run did not finish within the time allowed for %0d moves", N_MOVES);
		$display("Test failed");
		$fatal(1);
	end

endmodule

`default_nettype wire
